/* src/frontend_macros.svh */
/* Build-time constants of the instruction front end.
   Include this file in any module that sizes the store or the credit pool. */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Words held by the instruction store
`define ROM_DEPTH 256

// Issue queue slots downstream, also the credit count after reset
`define CREDIT_MAX 4

// NOP word that fills a cycle without an issue
`define BUBBLE_INSTR 16'h0800

`endif

/* src/frontendPkg.sv */
/* Types, opcode constants and fetch states shared by the front end.
   Modules take these by a wildcard import in their header. */
package frontendPkg;

   typedef logic [15:0] pcT;      // Byte address
   typedef logic [15:0] instrT;
   typedef logic [4:0]  opcodeT;  // Instruction bits 15:11
   typedef logic [2:0]  regAddrT;
   typedef logic [2:0]  immSelT;
   typedef logic [2:0]  creditT;

   // Supported opcodes, anything else is illegal
   localparam opcodeT OP_HALT = 5'b00000;
   localparam opcodeT OP_NOP  = 5'b00001;
   localparam opcodeT OP_ADDI = 5'b01000;
   localparam opcodeT OP_LD   = 5'b10001;
   localparam opcodeT OP_ST   = 5'b10000;
   localparam opcodeT OP_LBI  = 5'b11000;
   localparam opcodeT OP_ALU  = 5'b11011;
   localparam opcodeT OP_BEQZ = 5'b01100;
   localparam opcodeT OP_JAL  = 5'b00110;

   // Immediate formats for the execute stage
   localparam immSelT IMM_NONE = 3'b000;
   localparam immSelT IMM_5S   = 3'b001;  // Bits 4:0, sign extended
   localparam immSelT IMM_8S   = 3'b010;  // Bits 7:0, sign extended
   localparam immSelT IMM_11S  = 3'b011;  // Jump displacement

   typedef enum logic {
      RUNNING,
      HALTED
   } fetchStateT;

endpackage

/* src/progCounter.sv */
/* Program counter with the run/halt state of the fetch stage.
   Advances by one word per issue, takes redirects, freezes after a halt. */
`timescale 1ns/1ns

module progCounter import frontendPkg::*; (
   input  logic clk,
   input  logic rstN,
   input  logic advance,
   input  logic redirect,
   input  pcT   redirectPc,
   input  logic haltIssued,
   output pcT   pc,
   output logic running
);

   fetchStateT stateQ;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         stateQ <= RUNNING;
         pc     <= '0;
      end else begin
         // Nothing moves once halted, redirects included
         if (stateQ == RUNNING) begin
            if (redirect)
               pc <= redirectPc;        // Redirect wins over advance
            else if (advance)
               pc <= pc + pcT'(2);
            if (haltIssued)
               stateQ <= HALTED;
         end
      end
   end

   assign running = rstN && (stateQ == RUNNING);  // Quiet while in reset

endmodule

/* src/instrRom.sv */
/* Instruction store, read combinationally at the PC.
   Filled through the write port before the program runs. */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module instrRom import frontendPkg::*; (
   input  logic  clk,
   input  logic  loadEn,
   input  pcT    loadAddr,
   input  instrT loadData,
   input  pcT    addr,
   output instrT instr
);

   localparam int ADDR_W = $clog2(`ROM_DEPTH);

   instrT mem [`ROM_DEPTH];

   // Word index, the byte bit is dropped
   logic [ADDR_W-1:0] rdIdx;
   logic [ADDR_W-1:0] wrIdx;

   assign rdIdx = addr[ADDR_W:1];
   assign wrIdx = loadAddr[ADDR_W:1];

   always_ff @(posedge clk) begin
      if (loadEn)
         mem[wrIdx] <= loadData;
   end

   assign instr = mem[rdIdx];  // Async read

endmodule

/* src/ctrlDecode.sv */
/* Opcode decoder for the front end control word and destination register.
   Purely combinational; used once for issue and once for hazard checks. */
`timescale 1ns/1ns

module ctrlDecode import frontendPkg::*; (
   input  instrT   instr,
   output logic    regWrite,
   output logic    memEnable,
   output logic    memWr,
   output logic    link,
   output logic    halt,
   output logic    ctrlErr,
   output immSelT  immSel,
   output regAddrT writeRegAddr
);

   opcodeT op;

   assign op = instr[15:11];

   always_comb begin
      regWrite     = 1'b0;
      memEnable    = 1'b0;
      memWr        = 1'b0;
      link         = 1'b0;
      halt         = 1'b0;
      ctrlErr      = 1'b0;
      immSel       = IMM_NONE;
      writeRegAddr = 3'b000;

      case (op)
         OP_HALT: halt = 1'b1;
         OP_NOP: ;
         OP_ADDI: begin
            regWrite     = 1'b1;
            writeRegAddr = instr[7:5];  // Rd, I-format
            immSel       = IMM_5S;
         end
         OP_LD: begin
            regWrite     = 1'b1;
            writeRegAddr = instr[7:5];
            memEnable    = 1'b1;
            immSel       = IMM_5S;
         end
         OP_ST: begin
            memEnable = 1'b1;
            memWr     = 1'b1;
            immSel    = IMM_5S;
         end
         OP_LBI: begin
            regWrite     = 1'b1;
            writeRegAddr = instr[10:8];  // Loads into Rs
            immSel       = IMM_8S;
         end
         OP_ALU: begin
            regWrite     = 1'b1;
            writeRegAddr = instr[4:2];  // Rd, R-format
         end
         OP_BEQZ: immSel = IMM_8S;
         OP_JAL: begin
            regWrite     = 1'b1;
            writeRegAddr = 3'b111;  // Return address in R7
            link         = 1'b1;
            immSel       = IMM_11S;
         end
         // Illegal opcode, no write and no memory access
         default: ctrlErr = 1'b1;
      endcase
   end

endmodule

/* src/hazardUnit.sv */
/* Scoreboard of destinations in the three stages past fetch.
   Stalls the fetched word while one of its sources is still pending. */
`timescale 1ns/1ns

module hazardUnit import frontendPkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  instrT   instr,
   input  logic    issued,
   input  logic    issuedWrite,
   input  regAddrT issuedDest,
   output logic    stall
);

   logic [2:0] slotValidQ;   // Index 0 is the youngest
   regAddrT    slotDestQ [3];
   logic       useRs;
   logic       useRt;
   regAddrT    rs;
   regAddrT    rt;

   assign rs = instr[10:8];
   assign rt = instr[7:5];

   // Source registers read by each opcode class
   always_comb begin
      useRs = 1'b0;
      useRt = 1'b0;
      case (opcodeT'(instr[15:11]))
         OP_ADDI, OP_LD, OP_BEQZ: useRs = 1'b1;
         OP_ST, OP_ALU: begin
            useRs = 1'b1;
            useRt = 1'b1;  // Store data or second ALU operand
         end
         default: ;
      endcase
   end

   always_comb begin
      stall = 1'b0;
      for (int i = 0; i < 3; i++) begin
         if (slotValidQ[i] && ((useRs && slotDestQ[i] == rs) ||
                               (useRt && slotDestQ[i] == rt)))
            stall = 1'b1;
      end
   end

   // Shift every cycle, an empty slot enters when nothing issues
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         slotValidQ <= '0;
      else
         slotValidQ <= {slotValidQ[1:0], issued & issuedWrite};
   end

   always_ff @(posedge clk) begin
      slotDestQ[0] <= issuedDest;
      slotDestQ[1] <= slotDestQ[0];
      slotDestQ[2] <= slotDestQ[1];
   end

endmodule

/* src/fetchStage.sv */
/* Fetch stage top: PC, instruction store, decode, hazard stall and credits.
   Issues one decoded word per cycle to the downstream queue when allowed. */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module fetchStage import frontendPkg::*; (
   input  logic    clk,
   input  logic    rstN,
   input  logic    loadEn,
   input  pcT      loadAddr,
   input  instrT   loadData,
   input  logic    creditReturn,
   input  logic    redirect,
   input  pcT      redirectPc,
   output logic    instrValid,
   output instrT   instr,
   output pcT      pc,
   output opcodeT  opcode,
   output regAddrT writeRegAddr,
   output logic    regWrite,
   output logic    memEnable,
   output logic    memWr,
   output immSelT  immSel,
   output logic    link,
   output logic    halt,
   output logic    ctrlErr
);

   instrT   romInstr;
   logic    running;
   logic    stall;
   logic    advance;
   logic    chkWrite;  // Fetched word writes a register
   regAddrT chkDest;
   creditT  creditQ;

   progCounter progCounterInst (
      .clk(clk), .rstN(rstN), .advance(advance), .redirect(redirect),
      .redirectPc(redirectPc), .haltIssued(halt & instrValid),
      .pc(pc), .running(running));

   instrRom instrRomInst (
      .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
      .addr(pc), .instr(romInstr));

   // Check copy, looks at the fetched word before the bubble mux
   ctrlDecode chkDecodeInst (
      .instr(romInstr), .regWrite(chkWrite), .memEnable(), .memWr(),
      .link(), .halt(), .ctrlErr(), .immSel(), .writeRegAddr(chkDest));

   hazardUnit hazardUnitInst (
      .clk(clk), .rstN(rstN), .instr(romInstr), .issued(instrValid),
      .issuedWrite(chkWrite), .issuedDest(chkDest), .stall(stall));

   // Issue needs a run state, no redirect, no hazard and a free slot
   assign instrValid = running && !redirect && !stall && (creditQ != '0);
   assign advance    = instrValid;

   assign instr  = instrValid ? romInstr : `BUBBLE_INSTR;  // Visible bubble
   assign opcode = instr[15:11];

   ctrlDecode issueDecodeInst (
      .instr(instr), .regWrite(regWrite), .memEnable(memEnable), .memWr(memWr),
      .link(link), .halt(halt), .ctrlErr(ctrlErr), .immSel(immSel),
      .writeRegAddr(writeRegAddr));

   // One credit per issue, one back per return, both may coincide
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         creditQ <= creditT'(`CREDIT_MAX);
      else
         creditQ <= creditQ - creditT'(instrValid) + creditT'(creditReturn);
   end

endmodule

/* test/fetchStage_sva.sv */
/* Assertions on reset, credit and halt behaviour of the fetch stage.
   Attached to the top level by a bind in the testbench. */
`timescale 1ns/1ns

module fetchStageSva import frontendPkg::*; (
   input logic   clk,
   input logic   rstN,
   input logic   instrValid,
   input logic   halt,
   input creditT creditQ
);

   logic haltSeenQ;  // A HALT has been issued

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)
         haltSeenQ <= 1'b0;
      else if (instrValid && halt)
         haltSeenQ <= 1'b1;
   end

   resetQuiet: assert property (@(posedge clk) !rstN |-> !instrValid)
      else $error("instrValid high while in reset");

   // Empty counter means back-pressure
   noCreditNoIssue: assert property (@(posedge clk) disable iff (!rstN)
      creditQ == '0 |-> !instrValid)
      else $error("issue with the credit counter at zero");

   haltIsFinal: assert property (@(posedge clk) disable iff (!rstN) haltSeenQ |-> !instrValid)
      else $error("issue after a HALT");

endmodule

/* test/fetchStageTb.sv */
/* Testbench for the fetch stage. Loads a random program, drives random credit
   returns and redirects, and checks each cycle against a reference model. */
`timescale 1ns/1ns
`include "frontend_macros.svh"

module fetchStageTb import frontendPkg::*; ();

   localparam int PROG_LEN   = 250;
   localparam int HALT_IDX   = 245;
   localparam int CLK_PERIOD = 8;

   logic    clk;
   logic    rstN;
   logic    loadEn, creditReturn, redirect;
   pcT      loadAddr, redirectPc, pc;
   instrT   loadData, instr;
   logic    instrValid, regWrite, memEnable, memWr, link, halt, ctrlErr;
   opcodeT  opcode;
   regAddrT writeRegAddr;
   immSelT  immSel;

   instrT      progMem [PROG_LEN];
   integer     seed = 32'hf985_c747;
   int         cycle, issueCount, valueErrors, otherErrors, postHalt, redirectsLeft;
   int         dueQ[$];      // Cycle in which each outstanding credit comes back
   int         mCredits;
   pcT         mPc;
   logic       mHalted, expValid, hazard;
   logic [2:0] slotValid;    // Model scoreboard, index 0 youngest
   regAddrT    slotDest [3];
   instrT      word;

   fetchStage fetchStage_inst (.*);

   bind fetchStage fetchStageSva fetchStageSvaInst (
      .clk(clk), .rstN(rstN), .instrValid(instrValid), .halt(halt), .creditQ(creditQ));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      #(40 * PROG_LEN * CLK_PERIOD);
      $display("Timeout: the program did not reach its HALT in time");
      $display("*** FAILED ***");
      $finish;
   end

   // {regWrite, dest[2:0], memEnable, memWr, immSel[2:0], link, halt, ctrlErr}
   function automatic logic [11:0] expectedCtrl(instrT w);
      logic [11:0] c;
      c = '0;
      case (opcodeT'(w[15:11]))
         OP_HALT: c[1] = 1'b1;
         OP_NOP: ;
         OP_ADDI: c = {1'b1, w[7:5], 2'b00, IMM_5S, 3'b000};
         OP_LD:   c = {1'b1, w[7:5], 2'b10, IMM_5S, 3'b000};
         OP_ST:   c = {4'b0000, 2'b11, IMM_5S, 3'b000};
         OP_LBI:  c = {1'b1, w[10:8], 2'b00, IMM_8S, 3'b000};
         OP_ALU:  c = {1'b1, w[4:2], 2'b00, IMM_NONE, 3'b000};
         OP_BEQZ: c = {4'b0000, 2'b00, IMM_8S, 3'b000};
         OP_JAL:  c = {1'b1, 3'b111, 2'b00, IMM_11S, 3'b100};
         default: c[0] = 1'b1;   // Illegal
      endcase
      return c;
   endfunction

   // Source of the word matches a pending destination
   function automatic logic readsPending(instrT w);
      opcodeT op;
      logic   useRs;
      logic   useRt;
      logic   hit;
      op    = w[15:11];
      useRs = op inside {OP_ADDI, OP_LD, OP_BEQZ, OP_ST, OP_ALU};
      useRt = op inside {OP_ST, OP_ALU};
      hit   = 1'b0;
      for (int i = 0; i < 3; i++) begin
         if (slotValid[i] && ((useRs && slotDest[i] == w[10:8]) ||
                              (useRt && slotDest[i] == w[7:5])))
            hit = 1'b1;
      end
      return hit;
   endfunction

   task automatic checkField(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp)
      else begin
         valueErrors++;
         $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic reportProblem(input string what);
      otherErrors++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   task driveInputs();
      creditReturn = 1'b0;
      redirect     = 1'b0;
      redirectPc   = pcT'($random(seed));  // Ignored unless redirect
      if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
         creditReturn = 1'b1;
         void'(dueQ.pop_front());
      end
      if (cycle > 4 && $unsigned($random(seed)) % 20 == 0 && (mHalted || redirectsLeft > 0)) begin
         redirect   = 1'b1;
         redirectPc = pcT'(2 * ($unsigned($random(seed)) % HALT_IDX));
         if (!mHalted)
            redirectsLeft--;
      end
   endtask

   task checkCycle();
      logic [11:0] ctrl;
      word     = progMem[mPc[8:1]];
      hazard   = readsPending(word);
      expValid = !mHalted && !redirect && (mCredits != 0) && !hazard;
      ctrl     = expectedCtrl(word);
      checkField("instrValid", 16'(instrValid), 16'(expValid));
      assert (!(instrValid && mHalted)) else reportProblem("instruction issued after HALT");
      assert (!(instrValid && mCredits == 0)) else reportProblem("issue with no credit left");
      assert (!(instrValid && hazard)) else reportProblem("issued word reads a pending register");
      if (instrValid && expValid) begin
         checkField("pc", pc, mPc);
         checkField("instr", instr, word);
         checkField("opcode", 16'(opcode), 16'(word[15:11]));
         checkField("regWrite", 16'(regWrite), 16'(ctrl[11]));
         checkField("writeRegAddr", 16'(writeRegAddr), 16'(ctrl[10:8]));
         checkField("memEnable", 16'(memEnable), 16'(ctrl[7]));
         checkField("memWr", 16'(memWr), 16'(ctrl[6]));
         checkField("immSel", 16'(immSel), 16'(ctrl[5:3]));
         checkField("link", 16'(link), 16'(ctrl[2]));
         checkField("halt", 16'(halt), 16'(ctrl[1]));
         checkField("ctrlErr", 16'(ctrlErr), 16'(ctrl[0]));
      end else if (!instrValid) begin
         checkField("instr", instr, `BUBBLE_INSTR);  // Bubble must show
      end
   endtask

   task updateModel();
      logic [11:0] ctrl;
      ctrl = expectedCtrl(word);
      if (!mHalted) begin
         if (redirect)
            mPc = redirectPc;
         else if (expValid)
            mPc = mPc + 16'd2;
         if (expValid && ctrl[1])
            mHalted = 1'b1;
      end
      slotDest[2] = slotDest[1];
      slotDest[1] = slotDest[0];
      slotDest[0] = ctrl[10:8];
      slotValid   = {slotValid[1:0], expValid && ctrl[11]};
      mCredits    = mCredits - int'(expValid) + int'(creditReturn);
      // Downstream queue holds whatever the DUT actually issued
      if (instrValid) begin
         issueCount++;
         dueQ.push_back(cycle + 1 + $unsigned($random(seed)) % 6);
         assert (dueQ.size() <= `CREDIT_MAX)
         else reportProblem("more issues outstanding than queue slots");
      end
      if (mHalted)
         postHalt++;
      cycle++;
   endtask

   initial begin : mainFlow
      opcodeT op;
      rstN         = 1'b0;
      loadEn       = 1'b0;
      loadAddr     = '0;
      loadData     = '0;
      creditReturn = 1'b0;
      redirect     = 1'b0;
      redirectPc   = '0;
      valueErrors  = 0;
      otherErrors  = 0;
      issueCount   = 0;

      // Random program, a few illegal opcodes, one HALT near the end
      for (int i = 0; i < PROG_LEN; i++) begin
         case ($unsigned($random(seed)) % 20)
            0: op = 5'b11111;
            1: op = 5'b00010;
            2: op = OP_NOP;
            3, 4, 5: op = OP_ADDI;
            6, 7: op = OP_LD;
            8, 9: op = OP_ST;
            10, 11: op = OP_LBI;
            12, 13, 14, 15: op = OP_ALU;
            16, 17: op = OP_BEQZ;
            default: op = OP_JAL;
         endcase
         progMem[i] = {op, 11'($random(seed))};
      end
      progMem[HALT_IDX] = {OP_HALT, 11'b0};

      // Reset is held over the whole load, then three idle cycles
      for (int i = 0; i < PROG_LEN; i++) begin
         @(posedge clk);
         #1;
         loadEn   = 1'b1;
         loadAddr = pcT'(2 * i);
         loadData = progMem[i];
      end
      @(posedge clk);
      #1;
      loadEn = 1'b0;
      repeat (3) @(posedge clk);
      #1;

      mPc           = '0;
      mHalted       = 1'b0;
      mCredits      = `CREDIT_MAX;
      slotValid     = '0;
      cycle         = 0;
      postHalt      = 0;
      redirectsLeft = 5;
      rstN          = 1'b1;

      while (postHalt < 40) begin
         driveInputs();
         #5;
         checkCycle();
         updateModel();
         @(posedge clk);
         #1;
      end

      $display("Run done: %0d issued, %0d value errors, %0d other errors",
               issueCount, valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+src
src/frontendPkg.sv
src/progCounter.sv
src/instrRom.sv
src/ctrlDecode.sv
src/hazardUnit.sv
src/fetchStage.sv
test/fetchStage_sva.sv
test/fetchStageTb.sv

/* Bender.yml */
package:
  name: fetch_stage

export_include_dirs:
  - src

sources:
  - files:
      - src/frontendPkg.sv
      - src/progCounter.sv
      - src/instrRom.sv
      - src/ctrlDecode.sv
      - src/hazardUnit.sv
      - src/fetchStage.sv
  - target: test
    files:
      - test/fetchStage_sva.sv
      - test/fetchStageTb.sv
